/* source/rob_pkg.sv */
package rob_pkg;

    // ROB sizing
    localparam int ROB_DEPTH  = 16;                  // Entries in the reorder buffer
    localparam int TAG_W      = 4;                   // ROB index width, log2 of depth
    localparam int CNT_W      = TAG_W + 1;           // Occupancy count, 0 to ROB_DEPTH

    // Architectural state
    localparam int REG_IDX_W  = 5;                   // x0..x31
    localparam int NUM_REGS   = 32;                  // x0 hardwired to zero
    localparam int XLEN       = 32;                  // Data and address width

    // Writeback sources
    localparam int NUM_WB_SRC = 3;                   // alu, mul, lsu
    localparam int WB_SEL_W   = $clog2(NUM_WB_SRC);  // Round-robin pointer width

endpackage

/* source/wb_arbiter.sv */
module wb_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       alu_valid,
    output logic                       alu_ready,
    input  logic [rob_pkg::TAG_W-1:0]  alu_tag,
    input  logic [rob_pkg::XLEN-1:0]   alu_value,
    input  logic                       alu_exc,
    input  logic                       mul_valid,
    output logic                       mul_ready,
    input  logic [rob_pkg::TAG_W-1:0]  mul_tag,
    input  logic [rob_pkg::XLEN-1:0]   mul_value,
    input  logic                       mul_exc,
    input  logic                       lsu_valid,
    output logic                       lsu_ready,
    input  logic [rob_pkg::TAG_W-1:0]  lsu_tag,
    input  logic [rob_pkg::XLEN-1:0]   lsu_value,
    input  logic [rob_pkg::XLEN-1:0]   lsu_addr,
    input  logic                       lsu_exc,
    output logic                       cpl_valid,
    output logic [rob_pkg::TAG_W-1:0]  cpl_tag,
    output logic [rob_pkg::XLEN-1:0]   cpl_value,
    output logic [rob_pkg::XLEN-1:0]   cpl_addr,
    output logic                       cpl_exc
);
    import rob_pkg::*;

    logic [NUM_WB_SRC-1:0] req;    // Bit 0 alu, 1 mul, 2 lsu
    logic [NUM_WB_SRC-1:0] grant;  // One-hot winner
    logic [WB_SEL_W-1:0]   prio;   // Source checked first this cycle
    logic [WB_SEL_W-1:0]   win;    // Winner index, feeds pointer update

    assign req = {lsu_valid, mul_valid, alu_valid};

    // Scan sources starting at prio, first requester wins
    always_comb begin
        int idx;
        grant = '0;
        win   = prio;
        for (int k = 0; k < NUM_WB_SRC; k++) begin
            idx = int'(prio) + k;
            if (idx >= NUM_WB_SRC) begin
                idx = idx - NUM_WB_SRC;               // Wrap around
            end
            if (req[idx] && grant == '0) begin
                grant[idx] = 1'b1;
                win        = WB_SEL_W'(idx);
            end
        end
    end

    // Pointer moves one past the winner so it goes last next time
    always_ff @(posedge clk) begin
        if (rst) begin
            prio <= '0;
        end else if (|grant) begin
            prio <= (win == WB_SEL_W'(NUM_WB_SRC - 1)) ? '0 : win + 1'b1;
        end
    end

    assign alu_ready = grant[0];                      // Handshake in grant cycle
    assign mul_ready = grant[1];
    assign lsu_ready = grant[2];
    assign cpl_valid = |grant;

    // Forward winner fields, grant is one-hot
    always_comb begin
        if (grant[2]) begin
            cpl_tag   = lsu_tag;
            cpl_value = lsu_value;
            cpl_addr  = lsu_addr;                     // Only LSU reports an address
            cpl_exc   = lsu_exc;
        end else if (grant[1]) begin
            cpl_tag   = mul_tag;
            cpl_value = mul_value;
            cpl_addr  = '0;
            cpl_exc   = mul_exc;
        end else begin
            cpl_tag   = alu_tag;                      // Don't care when no grant
            cpl_value = alu_value;
            cpl_addr  = '0;
            cpl_exc   = alu_exc;
        end
    end

    // Two sources never handshake in the same cycle
    a_one_ready: assert property (@(posedge clk) disable iff (rst)
        $onehot0({lsu_ready, mul_ready, alu_ready}));

endmodule

/* source/reorder_buffer.sv */
module reorder_buffer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          disp_valid,
    output logic                          disp_ready,
    input  logic [rob_pkg::XLEN-1:0]      disp_pc,
    input  logic [rob_pkg::REG_IDX_W-1:0] disp_rd,
    input  logic                          disp_reg_write,
    input  logic                          disp_is_store,
    output logic [rob_pkg::TAG_W-1:0]     disp_tag,
    input  logic                          cpl_valid,
    input  logic [rob_pkg::TAG_W-1:0]     cpl_tag,
    input  logic [rob_pkg::XLEN-1:0]      cpl_value,
    input  logic [rob_pkg::XLEN-1:0]      cpl_addr,
    input  logic                          cpl_exc,
    output logic                          commit_valid,
    output logic [rob_pkg::TAG_W-1:0]     commit_tag,
    output logic [rob_pkg::REG_IDX_W-1:0] commit_rd,
    output logic [rob_pkg::XLEN-1:0]      commit_value,
    output logic [rob_pkg::XLEN-1:0]      commit_addr,
    output logic                          commit_reg_write,
    output logic                          commit_store,
    output logic                          flush,
    output logic [rob_pkg::XLEN-1:0]      epc
);
    import rob_pkg::*;

    // Per-entry status flags
    logic [ROB_DEPTH-1:0] ent_valid;              // Slot allocated
    logic [ROB_DEPTH-1:0] ent_ready;              // Result written back
    logic [ROB_DEPTH-1:0] ent_exc;                // Result carries a fault
    logic [ROB_DEPTH-1:0] ent_reg_write;          // Writes rd on retire
    logic [ROB_DEPTH-1:0] ent_is_store;           // Store, value is store data

    // Per-entry payload
    logic [XLEN-1:0]      ent_pc    [ROB_DEPTH];  // For EPC
    logic [REG_IDX_W-1:0] ent_rd    [ROB_DEPTH];
    logic [XLEN-1:0]      ent_value [ROB_DEPTH];  // Reg result or store data
    logic [XLEN-1:0]      ent_addr  [ROB_DEPTH];  // Store address from LSU

    logic [TAG_W-1:0]     head;                   // Oldest entry
    logic [TAG_W-1:0]     tail;                   // Next free slot
    logic [CNT_W-1:0]     count;                  // Live entries

    logic disp_fire;
    logic cpl_fire;
    logic head_ready;
    logic retire;
    logic take_exc;

    assign disp_ready = (count != CNT_W'(ROB_DEPTH)) && !flush;  // Hold off in flush cycle
    assign disp_tag   = tail;                                     // Tag equals slot index
    assign disp_fire  = disp_valid && disp_ready;
    assign cpl_fire   = cpl_valid && !flush;      // Stale results dropped
    assign head_ready = ent_valid[head] && ent_ready[head];
    assign take_exc   = head_ready && ent_exc[head];
    assign retire     = head_ready && !ent_exc[head];

    // Control state, the exception branch wipes the whole window
    always_ff @(posedge clk) begin
        if (rst || take_exc) begin
            ent_valid <= '0;
            ent_ready <= '0;
            ent_exc   <= '0;
            head      <= '0;
            tail      <= '0;
            count     <= '0;
        end else begin
            if (disp_fire) begin
                ent_valid[tail] <= 1'b1;
                ent_ready[tail] <= 1'b0;          // Waits for its completion
                ent_exc[tail]   <= 1'b0;
                tail            <= tail + 1'b1;   // Wraps at depth
            end
            if (cpl_fire) begin
                ent_ready[cpl_tag] <= 1'b1;
                ent_exc[cpl_tag]   <= cpl_exc;
            end
            if (retire) begin
                ent_valid[head] <= 1'b0;          // Free slot
                head            <= head + 1'b1;
            end
            count <= count + CNT_W'(disp_fire) - CNT_W'(retire);
        end
    end

    // Registered commit and flush strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid <= 1'b0;
            flush        <= 1'b0;
        end else begin
            commit_valid <= retire;
            flush        <= take_exc;             // One-cycle pulse
        end
    end

    // Payload storage and commit fields
    always_ff @(posedge clk) begin
        if (disp_fire) begin
            ent_pc[tail]        <= disp_pc;
            ent_rd[tail]        <= disp_rd;
            ent_reg_write[tail] <= disp_reg_write;
            ent_is_store[tail]  <= disp_is_store;
        end
        if (cpl_fire) begin
            ent_value[cpl_tag] <= cpl_value;
            ent_addr[cpl_tag]  <= cpl_addr;
        end
        if (retire) begin
            commit_tag       <= head;
            commit_rd        <= ent_rd[head];
            commit_value     <= ent_value[head];
            commit_addr      <= ent_addr[head];
            commit_reg_write <= ent_reg_write[head] && !ent_is_store[head];  // Stores never write rd
            commit_store     <= ent_is_store[head];
        end
        if (take_exc) begin
            epc <= ent_pc[head];                  // Faulting instruction
        end
    end

    // Completion only for a live tag
    a_cpl_live: assert property (@(posedge clk) disable iff (rst)
        cpl_fire |-> ent_valid[cpl_tag]);

    // Count and valid flags agree, no overwrite of a live slot
    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        disp_fire |-> !ent_valid[tail]);

    a_flush_excl: assert property (@(posedge clk) disable iff (rst)
        !(flush && commit_valid));

endmodule

/* source/arch_regfile.sv */
module arch_regfile (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wr_en,
    input  logic [rob_pkg::REG_IDX_W-1:0] wr_idx,
    input  logic [rob_pkg::XLEN-1:0]      wr_data,
    input  logic [rob_pkg::REG_IDX_W-1:0] rd_idx,
    output logic [rob_pkg::XLEN-1:0]      rd_data
);
    import rob_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];             // Committed state

    // Single write port from retirement
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin  // x0 stays zero
            regs[wr_idx] <= wr_data;
        end
    end

    // Async read, new value visible the cycle after the write edge
    assign rd_data = regs[rd_idx];

endmodule

/* source/rob_core_top.sv */
module rob_core_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          disp_valid,
    output logic                          disp_ready,
    input  logic [rob_pkg::XLEN-1:0]      disp_pc,
    input  logic [rob_pkg::REG_IDX_W-1:0] disp_rd,
    input  logic                          disp_reg_write,
    input  logic                          disp_is_store,
    output logic [rob_pkg::TAG_W-1:0]     disp_tag,
    input  logic                          alu_valid,
    output logic                          alu_ready,
    input  logic [rob_pkg::TAG_W-1:0]     alu_tag,
    input  logic [rob_pkg::XLEN-1:0]      alu_value,
    input  logic                          alu_exc,
    input  logic                          mul_valid,
    output logic                          mul_ready,
    input  logic [rob_pkg::TAG_W-1:0]     mul_tag,
    input  logic [rob_pkg::XLEN-1:0]      mul_value,
    input  logic                          mul_exc,
    input  logic                          lsu_valid,
    output logic                          lsu_ready,
    input  logic [rob_pkg::TAG_W-1:0]     lsu_tag,
    input  logic [rob_pkg::XLEN-1:0]      lsu_value,
    input  logic [rob_pkg::XLEN-1:0]      lsu_addr,
    input  logic                          lsu_exc,
    output logic                          commit_valid,
    output logic [rob_pkg::TAG_W-1:0]     commit_tag,
    output logic [rob_pkg::REG_IDX_W-1:0] commit_rd,
    output logic [rob_pkg::XLEN-1:0]      commit_value,
    output logic [rob_pkg::XLEN-1:0]      commit_addr,
    output logic                          commit_reg_write,
    output logic                          commit_store,
    output logic                          flush,
    output logic [rob_pkg::XLEN-1:0]      epc,
    input  logic [rob_pkg::REG_IDX_W-1:0] rf_rd_idx,
    output logic [rob_pkg::XLEN-1:0]      rf_rd_data
);
    import rob_pkg::*;

    // Merged completion port, arbiter to ROB
    logic             cpl_valid;
    logic [TAG_W-1:0] cpl_tag;
    logic [XLEN-1:0]  cpl_value;
    logic [XLEN-1:0]  cpl_addr;
    logic             cpl_exc;

    logic             rf_wr_en;                   // Retired register write

    assign rf_wr_en = commit_valid && commit_reg_write;

    wb_arbiter u_arb (.*);                        // Port names match one to one

    reorder_buffer u_rob (.*);

    arch_regfile u_rf (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (rf_wr_en),
        .wr_idx  (commit_rd),
        .wr_data (commit_value),
        .rd_idx  (rf_rd_idx),
        .rd_data (rf_rd_data)
    );

endmodule

/* testbench/rob_checker.sv */
module rob_checker (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          disp_valid, disp_ready,
    input  logic                          disp_reg_write, disp_is_store,
    input  logic [rob_pkg::XLEN-1:0]      disp_pc,
    input  logic [rob_pkg::REG_IDX_W-1:0] disp_rd,
    input  logic [rob_pkg::TAG_W-1:0]     disp_tag,
    input  logic                          alu_valid, alu_ready, alu_exc,
    input  logic [rob_pkg::TAG_W-1:0]     alu_tag,
    input  logic [rob_pkg::XLEN-1:0]      alu_value,
    input  logic                          mul_valid, mul_ready, mul_exc,
    input  logic [rob_pkg::TAG_W-1:0]     mul_tag,
    input  logic [rob_pkg::XLEN-1:0]      mul_value,
    input  logic                          lsu_valid, lsu_ready, lsu_exc,
    input  logic [rob_pkg::TAG_W-1:0]     lsu_tag,
    input  logic [rob_pkg::XLEN-1:0]      lsu_value, lsu_addr,
    input  logic                          commit_valid, commit_reg_write, commit_store,
    input  logic [rob_pkg::TAG_W-1:0]     commit_tag,
    input  logic [rob_pkg::REG_IDX_W-1:0] commit_rd,
    input  logic [rob_pkg::XLEN-1:0]      commit_value, commit_addr,
    input  logic                          flush,
    input  logic [rob_pkg::XLEN-1:0]      epc,
    input  logic [rob_pkg::REG_IDX_W-1:0] rf_rd_idx,
    input  logic [rob_pkg::XLEN-1:0]      rf_rd_data,
    output int                            chk_errors,
    output int                            chk_in_flight,
    output int                            chk_commits
);
    import rob_pkg::*;

    logic [TAG_W-1:0]     q [$];                   // Tags in program order
    logic [XLEN-1:0]      m_pc   [ROB_DEPTH];
    logic [XLEN-1:0]      m_val  [ROB_DEPTH];      // Reported result
    logic [XLEN-1:0]      m_addr [ROB_DEPTH];      // Zero unless from LSU
    logic [REG_IDX_W-1:0] m_rd   [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] m_rw, m_st, m_exc;
    logic [ROB_DEPTH-1:0] m_done;                  // Result seen
    logic [ROB_DEPTH-1:0] m_live;                  // Dispatched, not retired
    logic [XLEN-1:0]      shadow [NUM_REGS];       // Expected register file
    logic [TAG_W-1:0]     exp_tail;                // Next tag dispatch should hand out
    int                   wait_cnt [NUM_WB_SRC];   // Cycles spent losing arbitration

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            $display("error %s expected %h actual %h", name, exp, act);
            chk_errors++;
        end
    endtask

    task automatic record_cpl(input logic [TAG_W-1:0] t, input logic [XLEN-1:0] v,
                              input logic [XLEN-1:0] a, input logic e);
        if (!m_live[t] || m_done[t]) begin
            $display("completion for tag %0d that was not waiting for a result", t);
            chk_errors++;
        end
        m_done[t] = 1'b1;
        m_val[t]  = v;
        m_addr[t] = a;
        m_exc[t]  = e;
    endtask

    task automatic track_wait(input int s, input logic v, input logic r);
        wait_cnt[s] = (v && !r) ? wait_cnt[s] + 1 : 0;
        if (wait_cnt[s] > 3) begin
            $display("source %0d waited more than three grants", s);
            chk_errors++;
            wait_cnt[s] = 0;
        end
    endtask

    // Pre-edge sampling, everything the DUT shows for this edge
    always @(posedge clk) begin
        logic [TAG_W-1:0] t;
        if (rst) begin
            q.delete();
            m_live      = '0;
            m_done      = '0;
            exp_tail    = '0;
            chk_errors  = 0;
            chk_commits = 0;
            wait_cnt    = '{default: 0};
            for (int i = 0; i < NUM_REGS; i++) begin
                shadow[i] = '0;
            end
        end else begin
            compare_field("rf_rd_data", shadow[rf_rd_idx], rf_rd_data);  // Before this edge's write
            track_wait(0, alu_valid, alu_ready);
            track_wait(1, mul_valid, mul_ready);
            track_wait(2, lsu_valid, lsu_ready);
            if (!flush) begin                            // ROB drops results in flush cycle
                if (alu_valid && alu_ready) record_cpl(alu_tag, alu_value, '0, alu_exc);
                if (mul_valid && mul_ready) record_cpl(mul_tag, mul_value, '0, mul_exc);
                if (lsu_valid && lsu_ready) record_cpl(lsu_tag, lsu_value, lsu_addr, lsu_exc);
            end
            if (commit_valid) begin
                if (q.size() == 0) begin
                    $display("commit seen with no instruction in flight");
                    chk_errors++;
                end else begin
                    t = q.pop_front();                   // Oldest must retire first
                    if (!m_done[t] || m_exc[t]) begin
                        $display("tag %0d committed without a clean result", t);
                        chk_errors++;
                    end
                    compare_field("commit_tag", 32'(t), 32'(commit_tag));
                    compare_field("commit_rd", 32'(m_rd[t]), 32'(commit_rd));
                    compare_field("commit_value", m_val[t], commit_value);
                    compare_field("commit_reg_write", 32'(m_rw[t] && !m_st[t]),
                                  32'(commit_reg_write));
                    compare_field("commit_store", 32'(m_st[t]), 32'(commit_store));
                    if (m_st[t]) compare_field("commit_addr", m_addr[t], commit_addr);
                    if (m_rw[t] && !m_st[t] && m_rd[t] != '0) shadow[m_rd[t]] = m_val[t];
                    m_live[t] = 1'b0;
                    chk_commits++;
                end
            end
            if (flush) begin
                if (q.size() == 0 || !m_exc[q[0]]) begin
                    $display("flush seen without a faulting instruction at the head");
                    chk_errors++;
                end else begin
                    compare_field("epc", m_pc[q[0]], epc);
                end
                compare_field("disp_tag", 32'd0, 32'(disp_tag));  // Tail back at zero
                q.delete();                              // Younger entries discarded
                m_live   = '0;
                exp_tail = '0;
            end
            if (disp_valid && disp_ready) begin
                compare_field("disp_tag", 32'(exp_tail), 32'(disp_tag));
                t = disp_tag;
                q.push_back(t);
                m_live[t] = 1'b1;
                m_done[t] = 1'b0;
                m_pc[t]   = disp_pc;
                m_rd[t]   = disp_rd;
                m_rw[t]   = disp_reg_write;
                m_st[t]   = disp_is_store;
                exp_tail++;
            end
            chk_in_flight = q.size();
        end
    end

endmodule

/* testbench/rob_tb.sv */
module rob_tb;
    import rob_pkg::*;

    logic                 clk, rst;
    logic                 disp_valid, disp_ready, disp_reg_write, disp_is_store;
    logic [XLEN-1:0]      disp_pc;
    logic [REG_IDX_W-1:0] disp_rd;
    logic [TAG_W-1:0]     disp_tag;
    logic                 alu_valid, alu_ready, alu_exc;
    logic [TAG_W-1:0]     alu_tag;
    logic [XLEN-1:0]      alu_value;
    logic                 mul_valid, mul_ready, mul_exc;
    logic [TAG_W-1:0]     mul_tag;
    logic [XLEN-1:0]      mul_value;
    logic                 lsu_valid, lsu_ready, lsu_exc;
    logic [TAG_W-1:0]     lsu_tag;
    logic [XLEN-1:0]      lsu_value, lsu_addr;
    logic                 commit_valid, commit_reg_write, commit_store, flush;
    logic [TAG_W-1:0]     commit_tag;
    logic [REG_IDX_W-1:0] commit_rd, rf_rd_idx;
    logic [XLEN-1:0]      commit_value, commit_addr, epc, rf_rd_data;
    int                   chk_errors, chk_in_flight, chk_commits;

    logic [31:0]          seed = 32'h760b_5fb8;
    logic [TAG_W-1:0]     pend_q [$];              // Dispatched, no source picked yet
    logic [ROB_DEPTH-1:0] is_st;                   // Per tag, stores go to LSU only
    logic                 exc_en;
    logic [TAG_W-1:0]     exc_tag;                 // Tag that faults in the LSU
    int                   disp_pct, cpl_pct, st_pct;
    int                   tb_errors, n_pass, n_fail;

    rob_core_top dut0 (.*);
    rob_checker  chk0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic present(input int s, input logic [TAG_W-1:0] t);
        logic [31:0] r;
        r = next_rand();
        if (s == 0) begin
            alu_valid = 1'b1;
            alu_tag   = t;
            alu_value = r;
        end else if (s == 1) begin
            mul_valid = 1'b1;
            mul_tag   = t;
            mul_value = r;
        end else begin
            lsu_valid = 1'b1;
            lsu_tag   = t;
            lsu_value = r;
            lsu_addr  = next_rand();
            lsu_exc   = exc_en && (t == exc_tag);
        end
    endtask

    // One clock, handshakes seen at the rising edge, new drive on the falling edge
    task automatic tick(input bit do_disp, input bit do_cpl, input int rd);
        logic [2:0]       hs;
        logic [2:0]       vs;
        logic [31:0]      r;
        logic [TAG_W-1:0] t;
        int               i;
        @(posedge clk);
        hs = {lsu_valid && lsu_ready, mul_valid && mul_ready, alu_valid && alu_ready};
        @(negedge clk);
        if (hs[0] || flush) alu_valid = 1'b0;
        if (hs[1] || flush) mul_valid = 1'b0;
        if (hs[2] || flush) lsu_valid = 1'b0;
        if (flush) begin
            pend_q.delete();                           // Window is gone
            exc_en = 1'b0;
        end
        vs = {lsu_valid, mul_valid, alu_valid};
        for (int s = 0; s < NUM_WB_SRC; s++) begin
            if (do_cpl && !vs[s] && pend_q.size() != 0 && next_rand() % 100 < cpl_pct) begin
                i = int'(next_rand() % pend_q.size());   // Random pick, out of order
                t = pend_q[i];
                if (s == 2 || !(is_st[t] || (exc_en && t == exc_tag))) begin
                    pend_q.delete(i);
                    present(s, t);
                end
            end
        end
        disp_valid = 1'b0;
        if (do_disp && disp_ready && next_rand() % 100 < disp_pct) begin
            r = next_rand();
            is_st[disp_tag] = (r % 100) < st_pct;
            disp_valid      = 1'b1;
            disp_is_store   = is_st[disp_tag];
            disp_reg_write  = r[8];                    // Stores may carry a stray write flag
            disp_rd         = r[13:9];
            disp_pc         = next_rand() & ~32'h3;    // Word aligned
            pend_q.push_back(disp_tag);
        end
        r = next_rand();
        rf_rd_idx = (rd < 0) ? r[4:0] : REG_IDX_W'(rd);
    endtask

    task automatic drain();
        int n;
        cpl_pct = 60;
        n = 0;
        while ((pend_q.size() != 0 || {lsu_valid, mul_valid, alu_valid} != '0 ||
                chk_in_flight != 0) && n < 2000) begin
            tick(1'b0, 1'b1, -1);
            n++;
        end
        if (n == 2000) begin
            $display("timeout waiting for the ROB to drain");
            tb_errors++;
        end
    endtask

    task automatic end_test(input string name, input int base);
        if (chk_errors + tb_errors > base) begin
            n_fail++;
            $display("test %s: FAIL", name);
        end else begin
            n_pass++;
            $display("test %s: PASS", name);
        end
    endtask

    initial begin
        int base;
        int n;
        rst = 1'b1;
        {disp_valid, disp_reg_write, disp_is_store, alu_valid, alu_exc} = '0;
        {mul_valid, mul_exc, lsu_valid, lsu_exc, exc_en} = '0;
        {disp_pc, disp_rd, alu_tag, alu_value, mul_tag, mul_value} = '0;
        {lsu_tag, lsu_value, lsu_addr, rf_rd_idx, exc_tag, is_st} = '0;
        {tb_errors, n_pass, n_fail} = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        base = chk_errors + tb_errors;                 // Mixed ALU and MUL stream
        disp_pct = 70;
        cpl_pct  = 50;
        st_pct   = 0;
        repeat (300) tick(1'b1, 1'b1, -1);
        drain();
        end_test("retire_order", base);

        base = chk_errors + tb_errors;                 // Checker compares every read
        for (int r = 0; r <= NUM_REGS; r++) tick(1'b0, 1'b0, r % NUM_REGS);
        end_test("reg_state", base);

        base = chk_errors + tb_errors;
        st_pct = 50;
        repeat (200) tick(1'b1, 1'b1, -1);
        drain();
        end_test("stores", base);

        base = chk_errors + tb_errors;                 // Six entries, fourth one faults
        disp_pct = 100;
        cpl_pct  = 0;
        st_pct   = 0;
        n = 0;
        while (pend_q.size() < 6 && n < 20) begin
            tick(1'b1, 1'b0, -1);
            n++;
        end
        exc_tag = pend_q[3];
        exc_en  = 1'b1;
        cpl_pct = 50;
        n = 0;
        while (!flush && n < 200) begin
            tick(1'b0, 1'b1, -1);
            n++;
        end
        if (!flush) begin
            $display("timeout waiting for flush after the faulting load");
            tb_errors++;
        end
        drain();
        end_test("exception_flush", base);

        base = chk_errors + tb_errors;                 // Fill all 16 slots, no results
        cpl_pct = 0;
        n = 0;
        while (disp_ready && n < 40) begin
            tick(1'b1, 1'b0, -1);
            n++;
        end
        if (disp_ready) begin
            $display("timeout waiting for disp_ready to drop with the ROB full");
            tb_errors++;
        end
        present(2, pend_q.pop_front());                // Release the oldest only
        n = 0;
        while (!disp_ready && n < 10) begin
            tick(1'b0, 1'b0, -1);
            n++;
        end
        if (!disp_ready) begin
            $display("timeout waiting for disp_ready after the oldest entry retired");
            tb_errors++;
        end
        drain();
        end_test("full_backpressure", base);

        base = chk_errors + tb_errors;                 // All sources busy every cycle
        disp_pct = 100;
        cpl_pct  = 100;
        repeat (300) tick(1'b1, 1'b1, -1);
        drain();
        end_test("contention", base);

        $display("tests %0d passed %0d failed %0d errors %0d commits %0d",
                 n_pass + n_fail, n_pass, n_fail, chk_errors + tb_errors, chk_commits);
        if (n_fail == 0 && chk_errors + tb_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
source/rob_pkg.sv
source/wb_arbiter.sv
source/reorder_buffer.sv
source/arch_regfile.sv
source/rob_core_top.sv
testbench/rob_checker.sv
testbench/rob_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the ROB testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module rob_tb -o rob_sim
./obj_dir/rob_sim > sim.log 2>&1
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
exit 0
